/* build.f */
+incdir+design
design/alu_pkg.sv
design/alu_issue_if.sv
design/alu_sequencer.sv
design/alu_datapath.sv
design/alu_flags.sv
design/alu_ccr.sv
design/alu_top.sv
test/alu_chk.sv
test/alu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the execution unit testbench with Verilator, run it, and scan the log.
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module alu_tb -f build.f -Mdir obj_dir \
    && ./obj_dir/Valu_tb > "$LOG" 2>&1
cat "$LOG" 2>/dev/null
grep -q "RESULT: FAIL" "$LOG" && { echo "Simulation reported errors"; exit 1; }
grep -q "RESULT: PASS" "$LOG" || { echo "No verdict found in $LOG"; exit 1; }
exit 0

/* test/alu_tb.sv */
/*
 * Table-driven testbench for alu_top, plus random logic rows and a condition sweep.
 * Expected values are worked out by hand from the 68000 flag rules.
 */
`default_nettype none

module alu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import alu_pkg::*;

    typedef struct packed {
        alu_op_e  op;
        op_size_e size;
        data_t    src;
        data_t    dst;
        bitpos_t  bitpos;
        ccr_t     pre;     // CCR written before the row.
        data_t    res;
        ccr_t     flags;
    } row_t;

    localparam int NUM_ROWS = 26;
    localparam int NUM_RAND = 16;
    localparam int WATCHDOG_CYCLES = (NUM_ROWS + NUM_RAND) * 10 + 32 * 20 + 60;
    localparam alu_op_e LOGIC_OPS [4] = '{OP_AND, OP_OR, OP_EOR, OP_NOT};

    // op, size, src, dst, bitpos, ccr before, result, ccr after.
    localparam row_t ROWS [NUM_ROWS] = '{
        '{OP_ADD,  BYTE, 32'h0000_0001, 32'h0000_007F, 5'd0,  5'h00, 32'h0000_0080, 5'h0A},
        '{OP_ADD,  WORD, 32'h0000_0001, 32'hABCD_FFFF, 5'd0,  5'h00, 32'h0000_0000, 5'h15},
        '{OP_ADD,  LONG, 32'h0000_0001, 32'h7FFF_FFFF, 5'd0,  5'h00, 32'h8000_0000, 5'h0A},
        '{OP_SUB,  LONG, 32'h0000_0001, 32'h0000_0000, 5'd0,  5'h00, 32'hFFFF_FFFF, 5'h19},
        '{OP_SUB,  BYTE, 32'h0000_0001, 32'h0000_0080, 5'd0,  5'h00, 32'h0000_007F, 5'h02},
        '{OP_CMP,  WORD, 32'h0000_0007, 32'h0000_0005, 5'd0,  5'h00, 32'h0000_0005, 5'h09},
        '{OP_NEG,  BYTE, 32'h0000_0000, 32'h0000_0000, 5'd0,  5'h1F, 32'h0000_0000, 5'h04},
        '{OP_NEG,  LONG, 32'h0000_0000, 32'h0000_0001, 5'd0,  5'h00, 32'hFFFF_FFFF, 5'h19},
        '{OP_ADDX, LONG, 32'h0000_0000, 32'hFFFF_FFFF, 5'd0,  5'h14, 32'h0000_0000, 5'h15},
        '{OP_ADDX, BYTE, 32'h0000_0001, 32'h0000_0001, 5'd0,  5'h14, 32'h0000_0003, 5'h00},
        '{OP_SUBX, WORD, 32'h0000_0000, 32'h0000_0001, 5'd0,  5'h10, 32'h0000_0000, 5'h00},
        '{OP_NEGX, BYTE, 32'h0000_0000, 32'h0000_0000, 5'd0,  5'h10, 32'h0000_00FF, 5'h19},
        '{OP_AND,  WORD, 32'h0000_0FF0, 32'h0000_F0F0, 5'd0,  5'h10, 32'h0000_00F0, 5'h10},
        '{OP_OR,   BYTE, 32'h0000_0001, 32'h0000_0080, 5'd0,  5'h00, 32'h0000_0081, 5'h08},
        '{OP_EOR,  LONG, 32'h1234_5678, 32'h1234_5678, 5'd0,  5'h13, 32'h0000_0000, 5'h14},
        '{OP_NOT,  BYTE, 32'h0000_0000, 32'h0012_3455, 5'd0,  5'h00, 32'h0000_00AA, 5'h08},
        '{OP_CLR,  WORD, 32'h0000_0000, 32'hFFFF_FFFF, 5'd0,  5'h1B, 32'h0000_0000, 5'h14},
        '{OP_BTST, LONG, 32'h0000_0000, 32'h0000_0001, 5'd0,  5'h04, 32'h0000_0001, 5'h00},
        '{OP_BCHG, LONG, 32'h0000_0000, 32'h0000_0000, 5'd15, 5'h00, 32'h0000_8000, 5'h04},
        '{OP_BCLR, LONG, 32'h0000_0000, 32'h8000_0001, 5'd31, 5'h1F, 32'h0000_0001, 5'h1B},
        '{OP_BSET, LONG, 32'h0000_0000, 32'h0000_0000, 5'd31, 5'h00, 32'h8000_0000, 5'h04},
        '{OP_ABCD, BYTE, 32'h0000_0028, 32'h0000_0019, 5'd0,  5'h04, 32'h0000_0047, 5'h00},
        '{OP_ABCD, BYTE, 32'h0000_0001, 32'h0000_0099, 5'd0,  5'h14, 32'h0000_0001, 5'h11},
        '{OP_ABCD, BYTE, 32'h0000_0050, 32'h0000_0050, 5'd0,  5'h00, 32'h0000_0000, 5'h11},
        '{OP_SBCD, BYTE, 32'h0000_0001, 32'h0000_0000, 5'd0,  5'h04, 32'h0000_0099, 5'h11},
        '{OP_SBCD, BYTE, 32'h0000_0012, 32'h0000_0045, 5'd0,  5'h10, 32'h0000_0032, 5'h00}
    };

    logic     CLK;
    logic     arst_n;
    logic     start;
    alu_op_e  op;
    op_size_e size;
    data_t    src;
    data_t    dst;
    bitpos_t  bitpos;
    logic     ack;
    logic     busy;
    logic     result_valid;
    data_t    result;
    logic     ccr_wr;
    ccr_t     ccr_in;
    ccr_t     ccr;
    cond_t    cond;
    logic     cond_true;
    int       checks;
    int       errors;

    alu_top DUT (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // ====================
    // Helpers
    // ====================
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic write_ccr(input ccr_t v);
        @(posedge CLK);
        ccr_wr <= 1'b1;
        ccr_in <= v;
        @(posedge CLK);
        ccr_wr <= 1'b0;
        @(negedge CLK);
        check("ccr", 32'(ccr), 32'(v));
    endtask

    // Issues one operation and waits at a falling edge for result_valid.
    task automatic issue_op(input alu_op_e o, input op_size_e sz, input data_t s,
                            input data_t d, input bitpos_t bp);
        int edges;
        @(posedge CLK);
        start  <= 1'b1;
        op     <= o;
        size   <= sz;
        src    <= s;
        dst    <= d;
        bitpos <= bp;
        @(posedge CLK);
        start <= 1'b0;
        edges = 1;
        @(negedge CLK);
        while (!result_valid && edges < 8) begin
            @(negedge CLK);
            edges++;
        end
        if (!result_valid) begin
            errors++;
            $display("result_valid never rose after start of %s", o.name());
        end else
            check("latency", 32'(edges), 32'd2);
    endtask

    task automatic release_ack();
        @(posedge CLK);
        ack <= 1'b1;
        @(posedge CLK);
        ack <= 1'b0;
        @(negedge CLK);
        check("busy", 32'(busy), 32'd0);
        check("result_valid", 32'(result_valid), 32'd0);
    endtask

    function automatic int size_msb(input op_size_e sz);
        case (sz)
            BYTE:    return 7;
            WORD:    return 15;
            default: return 31;
        endcase
    endfunction

    function automatic data_t logic_expect(input alu_op_e o, input op_size_e sz,
                                           input data_t s, input data_t d);
        data_t raw;
        case (o)
            OP_AND:  raw = d & s;
            OP_OR:   raw = d | s;
            OP_EOR:  raw = d ^ s;
            default: raw = ~d;
        endcase
        if (sz == BYTE)
            return raw & 32'h0000_00FF;
        if (sz == WORD)
            return raw & 32'h0000_FFFF;
        return raw;
    endfunction

    // Branch conditions in 68000 order.
    function automatic logic cond_expect(input ccr_t f, input int c);
        logic n, z, v, cy;
        n  = f[3];
        z  = f[2];
        v  = f[1];
        cy = f[0];
        case (c)
            0:       return 1'b1;
            1:       return 1'b0;
            2:       return !cy && !z;
            3:       return cy || z;
            4:       return !cy;
            5:       return cy;
            6:       return !z;
            7:       return z;
            8:       return !v;
            9:       return v;
            10:      return !n;
            11:      return n;
            12:      return n == v;
            13:      return n != v;
            14:      return !z && (n == v);
            default: return z || (n != v);
        endcase
    endfunction

    // Ignored start and ccr_wr during DONE, then a late ack.
    task automatic handshake_test();
        write_ccr(5'h00);
        issue_op(OP_ADD, LONG, 32'h0000_0005, 32'h0000_0003, 5'd0);
        @(posedge CLK);
        start  <= 1'b1;
        op     <= OP_SUB;
        src    <= 32'h0000_0100;
        ccr_wr <= 1'b1;
        ccr_in <= 5'h1F;
        @(posedge CLK);
        start  <= 1'b0;
        ccr_wr <= 1'b0;
        repeat (4) begin
            @(negedge CLK);
            check("result", result, 32'h0000_0008);
            check("result_valid", 32'(result_valid), 32'd1);
            check("ccr", 32'(ccr), 32'h00);
        end
        release_ack();
        @(negedge CLK);
        check("busy", 32'(busy), 32'd0);    // The dropped start left no work behind.
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        data_t    rs;
        data_t    rd;
        data_t    exp_res;
        ccr_t     pre;
        alu_op_e  o;
        op_size_e sz;
        checks = 0;
        errors = 0;
        void'($urandom(32'h00025ff0));
        arst_n = 1'b0;
        start  = 1'b0;
        op     = OP_ADD;
        size   = BYTE;
        src    = '0;
        dst    = '0;
        bitpos = '0;
        ack    = 1'b0;
        ccr_wr = 1'b0;
        ccr_in = '0;
        cond   = '0;
        repeat (4) @(posedge CLK);
        arst_n <= 1'b1;
        @(negedge CLK);
        check("busy", 32'(busy), 32'd0);
        check("result_valid", 32'(result_valid), 32'd0);
        check("result", result, 32'd0);
        check("ccr", 32'(ccr), 32'd0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            write_ccr(ROWS[i].pre);
            issue_op(ROWS[i].op, ROWS[i].size, ROWS[i].src, ROWS[i].dst, ROWS[i].bitpos);
            check("result", result, ROWS[i].res);
            check("ccr", 32'(ccr), 32'(ROWS[i].flags));
            release_ack();
        end

        for (int i = 0; i < NUM_RAND; i++) begin
            o   = LOGIC_OPS[$urandom % 4];
            sz  = op_size_e'(2'($urandom % 3));
            rs  = $urandom;
            rd  = $urandom;
            pre = ccr_t'($urandom);
            exp_res = logic_expect(o, sz, rs, rd);
            write_ccr(pre);
            issue_op(o, sz, rs, rd, 5'd0);
            check("result", result, exp_res);
            check("ccr", 32'(ccr), 32'({pre[4], exp_res[size_msb(sz)], exp_res == '0, 2'b00}));
            release_ack();
        end

        handshake_test();

        for (int v = 0; v < 32; v++) begin
            write_ccr(ccr_t'(v));
            for (int c = 0; c < 16; c++) begin
                @(posedge CLK);
                cond <= cond_t'(c);
                @(negedge CLK);
                check("cond_true", 32'(cond_true), 32'(cond_expect(ccr_t'(v), c)));
            end
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("Watchdog expired after %0d cycles, test did not finish", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* test/alu_chk.sv */
/*
 * Handshake properties of the sequencer, bound into every alu_sequencer.
 * Checks are disabled while arst_n is low.
 */
`default_nettype none

module alu_chk (
    input logic CLK,
    input logic arst_n,
    input logic start,
    input logic ack,
    input logic busy,
    input logic result_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // ====================
    // Handshake
    // ====================
    valid_needs_busy: assert property (@(posedge CLK) disable iff (!arst_n)
        result_valid |-> busy)
        else $error("result_valid high while busy is low");

    valid_held_until_ack: assert property (@(posedge CLK) disable iff (!arst_n)
        result_valid && !ack |=> result_valid)
        else $error("result_valid dropped before ack");

    // Busy may only rise from idle on a start.
    busy_rise_from_idle: assert property (@(posedge CLK) disable iff (!arst_n)
        $rose(busy) |-> $past(start) && !$past(busy))
        else $error("busy rose without an accepted start");

endmodule

bind alu_sequencer alu_chk u_chk (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .start        (start),
    .ack          (ack),
    .busy         (busy),
    .result_valid (result_valid)
);

`default_nettype wire

/* design/alu_top.sv */
/*
 * Integer execution unit top level with plain ports.
 * Result is valid two edges after an accepted start and holds until ack.
 */
`default_nettype none

module alu_top (
    input  logic              CLK,
    input  logic              arst_n,
    input  logic              start,
    input  alu_pkg::alu_op_e  op,
    input  alu_pkg::op_size_e size,
    input  alu_pkg::data_t    src,
    input  alu_pkg::data_t    dst,
    input  alu_pkg::bitpos_t  bitpos,
    input  logic              ack,
    output logic              busy,
    output logic              result_valid,
    output alu_pkg::data_t    result,
    input  logic              ccr_wr,
    input  alu_pkg::ccr_t     ccr_in,
    output alu_pkg::ccr_t     ccr,
    input  alu_pkg::cond_t    cond,
    output logic              cond_true
);
    import alu_pkg::*;

    ccr_t new_flags;

    alu_issue_if issue ();

    alu_sequencer u_seq (
        .CLK          (CLK),
        .arst_n       (arst_n),
        .start        (start),
        .op           (op),
        .size         (size),
        .src          (src),
        .dst          (dst),
        .bitpos       (bitpos),
        .ack          (ack),
        .busy         (busy),
        .result_valid (result_valid),
        .issue        (issue.seq)
    );

    alu_datapath u_dp (
        .CLK    (CLK),
        .arst_n (arst_n),
        .issue  (issue.exe),
        .ccr_q  (ccr),
        .result (result)
    );

    alu_flags u_flags (
        .issue     (issue.exe),
        .ccr_q     (ccr),
        .new_flags (new_flags)
    );

    // Direct CCR writes only land while the unit is idle.
    alu_ccr u_ccr (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .exec      (issue.exec),
        .new_flags (new_flags),
        .ccr_wr    (ccr_wr & ~busy),
        .ccr_in    (ccr_in),
        .cond      (cond),
        .ccr_q     (ccr),
        .cond_true (cond_true)
    );

endmodule

`default_nettype wire

/* design/alu_ccr.sv */
/*
 * Condition-code register and branch condition test.
 * exec load wins over a direct write in the same cycle.
 */
`default_nettype none

module alu_ccr (
    input  logic           CLK,
    input  logic           arst_n,
    input  logic           exec,
    input  alu_pkg::ccr_t  new_flags,
    input  logic           ccr_wr,
    input  alu_pkg::ccr_t  ccr_in,
    input  alu_pkg::cond_t cond,
    output alu_pkg::ccr_t  ccr_q,
    output logic           cond_true
);
    import alu_pkg::*;

    logic n, z, v, c;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n)
            ccr_q <= '0;
        else if (exec)
            ccr_q <= new_flags;
        else if (ccr_wr)
            ccr_q <= ccr_in;
    end

    assign n = ccr_q[FLAG_N];
    assign z = ccr_q[FLAG_Z];
    assign v = ccr_q[FLAG_V];
    assign c = ccr_q[FLAG_C];

    // ====================
    // Condition decode
    // ====================
    always_comb begin
        case (cond)
            CC_T:  cond_true = 1'b1;
            CC_F:  cond_true = 1'b0;
            CC_HI: cond_true = ~c & ~z;
            CC_LS: cond_true = c | z;
            CC_CC: cond_true = ~c;
            CC_CS: cond_true = c;
            CC_NE: cond_true = ~z;
            CC_EQ: cond_true = z;
            CC_VC: cond_true = ~v;
            CC_VS: cond_true = v;
            CC_PL: cond_true = ~n;
            CC_MI: cond_true = n;
            CC_GE: cond_true = ~(n ^ v);
            CC_LT: cond_true = n ^ v;
            CC_GT: cond_true = ~z & ~(n ^ v);    // Signed greater.
            CC_LE: cond_true = z | (n ^ v);
        endcase
    end

endmodule

`default_nettype wire

/* design/alu_flags.sv */
/*
 * Combinational XNZVC for the issued operation, from the latched operands.
 * BCD keeps N and V unchanged; the 68000 leaves them undefined.
 */
`default_nettype none

module alu_flags (
    alu_issue_if.exe      issue,
    input  alu_pkg::ccr_t ccr_q,
    output alu_pkg::ccr_t new_flags
);
    import alu_pkg::*;

    data_t      src_x;
    data_t      dst_x;
    data_t      arith_res;
    data_t      logic_res;
    logic [8:0] bcd_res;
    logic [4:0] msb;
    logic       rm, sm, dm, lm;
    logic       arith_zero;
    logic       arith_z;
    logic       x_form;

    assign src_x     = sign_ext(issue.src, issue.size);
    assign dst_x     = sign_ext(issue.dst, issue.size);
    assign arith_res = arith_result(issue.op, dst_x, src_x, ccr_q[FLAG_X]);
    assign logic_res = logic_result(issue.op, issue.dst, issue.src);
    assign bcd_res   = bcd_byte(issue.op == OP_SBCD, issue.dst[7:0], issue.src[7:0],
                                ccr_q[FLAG_X]);

    always_comb begin
        case (issue.size)
            BYTE:    msb = 5'd7;
            WORD:    msb = 5'd15;
            default: msb = 5'd31;
        endcase
    end

    // Sign bits at the operand size.
    assign rm = arith_res[msb];
    assign sm = src_x[msb];
    assign dm = dst_x[msb];
    assign lm = logic_res[msb];

    // Extended forms can only clear Z, so multi-precision chains work.
    assign x_form     = (issue.op == OP_ADDX) || (issue.op == OP_SUBX) || (issue.op == OP_NEGX);
    assign arith_zero = (zero_ext(arith_res, issue.size) == '0);
    assign arith_z    = x_form ? (arith_zero & ccr_q[FLAG_Z]) : arith_zero;

    // ====================
    // Flag rules
    // ====================
    always_comb begin
        new_flags = ccr_q;    // Unchanged unless listed.
        case (issue.op)
            OP_ADD, OP_ADDX: begin
                new_flags[FLAG_C] = (sm & dm) | (~rm & sm) | (~rm & dm);
                new_flags[FLAG_X] = new_flags[FLAG_C];
                new_flags[FLAG_V] = (~rm & sm & dm) | (rm & ~sm & ~dm);
                new_flags[FLAG_N] = rm;
                new_flags[FLAG_Z] = arith_z;
            end
            OP_SUB, OP_SUBX, OP_CMP: begin
                new_flags[FLAG_C] = (sm & ~dm) | (rm & sm) | (rm & ~dm);
                if (issue.op != OP_CMP)
                    new_flags[FLAG_X] = new_flags[FLAG_C];
                new_flags[FLAG_V] = (~rm & ~sm & dm) | (rm & sm & ~dm);
                new_flags[FLAG_N] = rm;
                new_flags[FLAG_Z] = arith_z;
            end
            OP_NEG, OP_NEGX: begin
                new_flags[FLAG_C] = dm | rm;              // Borrow unless both zero.
                new_flags[FLAG_X] = dm | rm;
                new_flags[FLAG_V] = dm & rm;
                new_flags[FLAG_N] = rm;
                new_flags[FLAG_Z] = arith_z;
            end
            OP_CLR:
                new_flags[FLAG_N:FLAG_C] = 4'b0100;
            OP_AND, OP_OR, OP_EOR, OP_NOT:
                new_flags[FLAG_N:FLAG_C] = {lm, zero_ext(logic_res, issue.size) == '0, 2'b00};
            OP_BTST, OP_BCHG, OP_BCLR, OP_BSET:
                new_flags[FLAG_Z] = ~issue.dst[issue.bitpos];    // Old bit value.
            OP_ABCD, OP_SBCD: begin
                new_flags[FLAG_X] = bcd_res[8];
                new_flags[FLAG_C] = bcd_res[8];
                if (bcd_res[7:0] != 8'h00)
                    new_flags[FLAG_Z] = 1'b0;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* design/alu_datapath.sv */
/*
 * Result computation and result register, loaded on exec only.
 * Bit operations work on the full 32-bit dst; BCD is byte only.
 */
`default_nettype none

module alu_datapath (
    input  logic           CLK,
    input  logic           arst_n,
    alu_issue_if.exe       issue,
    input  alu_pkg::ccr_t  ccr_q,
    output alu_pkg::data_t result
);
    import alu_pkg::*;

    data_t      src_x;
    data_t      dst_x;
    data_t      arith_res;
    data_t      logic_res;
    data_t      bit_res;
    data_t      res_d;
    logic [8:0] bcd_res;

    // Signed view at the operand size.
    assign src_x = sign_ext(issue.src, issue.size);
    assign dst_x = sign_ext(issue.dst, issue.size);

    // ====================
    // Operation results
    // ====================
    assign arith_res = arith_result(issue.op, dst_x, src_x, ccr_q[FLAG_X]);
    assign logic_res = logic_result(issue.op, issue.dst, issue.src);
    assign bcd_res   = bcd_byte(issue.op == OP_SBCD, issue.dst[7:0], issue.src[7:0],
                                ccr_q[FLAG_X]);

    always_comb begin
        bit_res = issue.dst;    // BTST leaves dst as is.
        case (issue.op)
            OP_BCHG: bit_res[issue.bitpos] = ~issue.dst[issue.bitpos];
            OP_BCLR: bit_res[issue.bitpos] = 1'b0;
            OP_BSET: bit_res[issue.bitpos] = 1'b1;
            default: ;
        endcase
    end

    // ====================
    // Result select
    // ====================
    always_comb begin
        case (issue.op)
            OP_ADD, OP_ADDX, OP_SUB, OP_SUBX, OP_NEG, OP_NEGX, OP_CLR:
                res_d = zero_ext(arith_res, issue.size);
            OP_CMP:
                res_d = zero_ext(issue.dst, issue.size);    // Compare only.
            OP_AND, OP_OR, OP_EOR, OP_NOT:
                res_d = zero_ext(logic_res, issue.size);
            OP_BTST, OP_BCHG, OP_BCLR, OP_BSET:
                res_d = bit_res;
            OP_ABCD, OP_SBCD:
                res_d = data_t'(bcd_res[7:0]);
            default:
                res_d = '0;
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n)
            result <= '0;
        else if (issue.exec)
            result <= res_d;
    end

endmodule

`default_nettype wire

/* design/alu_sequencer.sv */
/*
 * Start/busy/valid/ack control, one operation in flight.
 * A start while busy is dropped. Host must release ack before the next start.
 */
`default_nettype none

module alu_sequencer (
    input  logic              CLK,
    input  logic              arst_n,
    input  logic              start,
    input  alu_pkg::alu_op_e  op,
    input  alu_pkg::op_size_e size,
    input  alu_pkg::data_t    src,
    input  alu_pkg::data_t    dst,
    input  alu_pkg::bitpos_t  bitpos,
    input  logic              ack,
    output logic              busy,
    output logic              result_valid,
    alu_issue_if.seq          issue
);
    import alu_pkg::*;

    seq_state_e state;
    seq_state_e state_nxt;
    logic       accept;

    assign accept = start && (state == IDLE);

    // ====================
    // State machine
    // ====================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (accept) state_nxt = EXEC;
            EXEC:    state_nxt = DONE;       // Result and CCR load here.
            DONE:    if (ack) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    // Operand latch.
    always_ff @(posedge CLK) begin
        if (accept) begin
            issue.op     <= op;
            issue.size   <= size;
            issue.src    <= src;
            issue.dst    <= dst;
            issue.bitpos <= bitpos;
        end
    end

    assign issue.exec   = (state == EXEC);
    assign busy         = (state != IDLE);   // Through EXEC and DONE.
    assign result_valid = (state == DONE);   // Held until ack.

endmodule

`default_nettype wire

/* design/alu_issue_if.sv */
/*
 * Latched operation as seen by the execution modules.
 * Fields hold their value from accept until the next accepted start.
 */
`default_nettype none

interface alu_issue_if;
    import alu_pkg::*;

    alu_op_e  op;
    op_size_e size;
    data_t    src;
    data_t    dst;
    bitpos_t  bitpos;
    logic     exec;      // Single-cycle compute strobe.

    modport seq (
        output op, size, src, dst, bitpos, exec
    );

    modport exe (
        input  op, size, src, dst, bitpos, exec
    );

endinterface

`default_nettype wire

/* design/alu_pkg.sv */
/*
 * Types and shared result functions for the execution unit.
 * BCD helpers assume packed BCD bytes; invalid digits give undefined decimals.
 */
`default_nettype none

`include "alu_params.svh"

package alu_pkg;

    typedef logic [`ALU_DATA_W-1:0] data_t;
    typedef logic [`ALU_FLAG_W-1:0] ccr_t;    // X,N,Z,V,C from bit 4 down.
    typedef logic [4:0]             bitpos_t;
    typedef logic [3:0]             cond_t;

    localparam int FLAG_X = 4;
    localparam int FLAG_N = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_V = 1;
    localparam int FLAG_C = 0;

    typedef enum logic [4:0] {
        OP_ADD, OP_ADDX, OP_SUB, OP_SUBX, OP_CMP, OP_NEG, OP_NEGX, OP_CLR,
        OP_AND, OP_OR, OP_EOR, OP_NOT,
        OP_BTST, OP_BCHG, OP_BCLR, OP_BSET,
        OP_ABCD, OP_SBCD
    } alu_op_e;

    typedef enum logic [1:0] {BYTE = 2'b00, WORD = 2'b01, LONG = 2'b10} op_size_e;

    // 68000 branch condition encoding.
    typedef enum logic [3:0] {
        CC_T  = 4'h0, CC_F  = 4'h1, CC_HI = 4'h2, CC_LS = 4'h3,
        CC_CC = 4'h4, CC_CS = 4'h5, CC_NE = 4'h6, CC_EQ = 4'h7,
        CC_VC = 4'h8, CC_VS = 4'h9, CC_PL = 4'hA, CC_MI = 4'hB,
        CC_GE = 4'hC, CC_LT = 4'hD, CC_GT = 4'hE, CC_LE = 4'hF
    } cond_e;

    typedef enum logic [1:0] {IDLE, EXEC, DONE} seq_state_e;

    // ====================
    // Sizing
    // ====================
    function automatic data_t sign_ext(input data_t v, input op_size_e sz);
        case (sz)
            BYTE:    return {{(`ALU_DATA_W-8){v[7]}}, v[7:0]};
            WORD:    return {{(`ALU_DATA_W-16){v[15]}}, v[15:0]};
            default: return v;
        endcase
    endfunction

    function automatic data_t zero_ext(input data_t v, input op_size_e sz);
        case (sz)
            BYTE:    return data_t'(v[7:0]);
            WORD:    return data_t'(v[15:0]);
            default: return v;
        endcase
    endfunction

    // ====================
    // Result functions
    // ====================
    // dst op src; NEG is 0 - dst. CLR falls to zero.
    function automatic data_t arith_result(input alu_op_e op, input data_t d,
                                           input data_t s, input logic x);
        case (op)
            OP_ADD:         return d + s;
            OP_ADDX:        return d + s + data_t'(x);
            OP_SUB, OP_CMP: return d - s;
            OP_SUBX:        return d - s - data_t'(x);
            OP_NEG:         return data_t'(0) - d;
            OP_NEGX:        return data_t'(0) - d - data_t'(x);
            default:        return '0;
        endcase
    endfunction

    function automatic data_t logic_result(input alu_op_e op, input data_t d, input data_t s);
        case (op)
            OP_AND:  return d & s;
            OP_OR:   return d | s;
            OP_EOR:  return d ^ s;
            default: return ~d;    // NOT.
        endcase
    endfunction

    // One decimal digit stage, returns {carry, digit}.
    function automatic logic [4:0] bcd_digit(input logic sub, input logic [3:0] d,
                                             input logic [3:0] s, input logic cin);
        logic [4:0] raw;
        logic [3:0] fix;
        fix = 4'(`BCD_ADJUST);
        if (sub)
            raw = {1'b0, d} - {1'b0, s} - {4'b0000, cin};
        else
            raw = {1'b0, d} + {1'b0, s} + {4'b0000, cin};
        if (raw > 5'(`BCD_DIGIT_MAX))
            return {1'b1, sub ? raw[3:0] - fix : raw[3:0] + fix};
        return {1'b0, raw[3:0]};
    endfunction

    // Packed BCD byte, returns {carry or borrow, result}.
    function automatic logic [8:0] bcd_byte(input logic sub, input logic [7:0] d,
                                            input logic [7:0] s, input logic x);
        logic [4:0] lo;
        logic [4:0] hi;
        lo = bcd_digit(sub, d[3:0], s[3:0], x);
        hi = bcd_digit(sub, d[7:4], s[7:4], lo[4]);
        return {hi, lo[3:0]};
    endfunction

endpackage

`default_nettype wire

/* design/alu_params.svh */
/*
 * Fixed 68000 widths and BCD digit limits.
 * Values are not meant to be changed per instance.
 */
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// Operand and result width.
`define ALU_DATA_W 32

// Condition flags X, N, Z, V, C.
`define ALU_FLAG_W 5

// Largest valid BCD digit and its decimal correction.
`define BCD_DIGIT_MAX 9
`define BCD_ADJUST 6

`endif
